// ==== trace_settings.svh ====
`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Trace unit sizing
//////////////////////////////////////////////////////////////////////

// Records held between capture and formatter
`define TRACE_FIFO_DEPTH 8

// Mnemonic field, left aligned and padded with spaces
`define TRACE_MNEM_CHARS 6

// Characters per text line, line feed included
// seq(2) + space + pc(8) + space + mnemonic + line feed
`define TRACE_LINE_CHARS 19

`endif

// ==== mips_isa_pkg.sv ====
package mips_isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // Primary opcode, instr[31:26]
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_COP0    = 6'b010000,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } op_t;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL     = 6'b000000,
        FN_SRL     = 6'b000010,
        FN_SRA     = 6'b000011,
        FN_SLLV    = 6'b000100,
        FN_SRLV    = 6'b000110,
        FN_SRAV    = 6'b000111,
        FN_JR      = 6'b001000,
        FN_JALR    = 6'b001001,
        FN_SYSCALL = 6'b001100,
        FN_BREAK   = 6'b001101,
        FN_MFHI    = 6'b010000,
        FN_MTHI    = 6'b010001,
        FN_MFLO    = 6'b010010,
        FN_MTLO    = 6'b010011,
        FN_MULT    = 6'b011000,
        FN_MULTU   = 6'b011001,
        FN_DIV     = 6'b011010,
        FN_DIVU    = 6'b011011,
        FN_ADD     = 6'b100000,
        FN_ADDU    = 6'b100001,
        FN_SUB     = 6'b100010,
        FN_SUBU    = 6'b100011,
        FN_AND     = 6'b100100,
        FN_OR      = 6'b100101,
        FN_XOR     = 6'b100110,
        FN_NOR     = 6'b100111,
        FN_SLT     = 6'b101010,
        FN_SLTU    = 6'b101011
    } funct_t;

    // REGIMM branch selector, instr[20:16]
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'b00000,
        RI_BGEZ   = 5'b00001,
        RI_BLTZAL = 5'b10000,
        RI_BGEZAL = 5'b10001
    } regimm_t;

    // COP0 function field, instr[5:0]
    typedef enum logic [5:0] {
        C0_TLBR  = 6'b000001,
        C0_TLBWI = 6'b000010,
        C0_TLBP  = 6'b001000,
        C0_ERET  = 6'b011000
    } cop0_funct_t;

endpackage

// ==== trace_pkg.sv ====
`include "trace_settings.svh"

package trace_pkg;

    //////////////////////////////////////////////////////////////////////
    // Records and characters
    //////////////////////////////////////////////////////////////////////

    // One retired instruction as held in the buffer
    typedef struct packed {
        logic [7:0]  seq;
        logic [31:0] pc;
        logic [31:0] instr;
    } trace_rec_t;

    // Output character, valid while strobe is high
    typedef struct packed {
        logic [7:0] data;
        logic       strobe;
    } trace_char_t;

    // Mnemonic text, first character in the top byte
    typedef logic [`TRACE_MNEM_CHARS*8-1:0] mnem_t;

    //////////////////////////////////////////////////////////////////////
    // Formatter FSM
    //////////////////////////////////////////////////////////////////////
    typedef enum logic {
        FMT_IDLE,
        FMT_SEND
    } fmt_state_t;

endpackage

// ==== trace_capture.sv ====
module trace_capture import trace_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        retire_valid,
    input  logic [31:0] retire_pc,
    input  logic [31:0] retire_instr,
    input  logic        full,
    output logic        push,
    output trace_rec_t  push_rec,
    output logic [15:0] drop_count
);

    logic [7:0] seq;
    logic       drop;

    // Record goes out in the same cycle as the retirement
    assign push = retire_valid && !full;
    assign drop = retire_valid && full;

    assign push_rec = '{seq: seq, pc: retire_pc, instr: retire_instr};

    //////////////////////////////////////////////////////////////////////
    // Sequence and drop counters
    //////////////////////////////////////////////////////////////////////

    // Every retirement takes a number, so gaps show drops downstream
    always_ff @(posedge clk) begin
        if (rst) begin
            seq <= '0;
        end else if (retire_valid) begin
            seq <= seq + 8'd1;
        end
    end

    // Saturates at all ones
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_count <= '0;
        end else if (drop && drop_count != 16'hFFFF) begin
            drop_count <= drop_count + 16'd1;
        end
    end

endmodule

// ==== trace_fifo.sv ====
`include "trace_settings.svh"

module trace_fifo import trace_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  trace_rec_t push_rec,
    input  logic       pop,
    output trace_rec_t head_rec,
    output logic       full,
    output logic       empty
);

    localparam int DEPTH = `TRACE_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    trace_rec_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wrap without relying on a power of two depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_rec = mem[rd_ptr];
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);

endmodule

// ==== inst_mnemonic_decoder.sv ====
`include "trace_settings.svh"

module inst_mnemonic_decoder import mips_isa_pkg::*; (
    input  logic [31:0]                    instr,
    output logic [`TRACE_MNEM_CHARS*8-1:0] mnemonic
);

    op_t         op;
    funct_t      funct;
    regimm_t     rt;
    cop0_funct_t c0_funct;

    assign op       = op_t'(instr[31:26]);
    assign funct    = funct_t'(instr[5:0]);
    assign rt       = regimm_t'(instr[20:16]);
    assign c0_funct = cop0_funct_t'(instr[5:0]);

    always_comb begin
        mnemonic = "N-R   ";
        case (op)
            //////////////////////////////////////////////////////////////////////
            // R-type, by function field
            //////////////////////////////////////////////////////////////////////
            OP_SPECIAL: begin
                case (funct)
                    FN_AND:     mnemonic = "AND   ";
                    FN_OR:      mnemonic = "OR    ";
                    FN_XOR:     mnemonic = "XOR   ";
                    FN_NOR:     mnemonic = "NOR   ";
                    // Shifts
                    FN_SLL:     mnemonic = "SLL   ";
                    FN_SRL:     mnemonic = "SRL   ";
                    FN_SRA:     mnemonic = "SRA   ";
                    FN_SLLV:    mnemonic = "SLLV  ";
                    FN_SRLV:    mnemonic = "SRLV  ";
                    FN_SRAV:    mnemonic = "SRAV  ";
                    // HI/LO moves
                    FN_MFHI:    mnemonic = "MFHI  ";
                    FN_MTHI:    mnemonic = "MTHI  ";
                    FN_MFLO:    mnemonic = "MFLO  ";
                    FN_MTLO:    mnemonic = "MTLO  ";
                    // Arithmetic
                    FN_ADD:     mnemonic = "ADD   ";
                    FN_ADDU:    mnemonic = "ADDU  ";
                    FN_SUB:     mnemonic = "SUB   ";
                    FN_SUBU:    mnemonic = "SUBU  ";
                    FN_SLT:     mnemonic = "SLT   ";
                    FN_SLTU:    mnemonic = "SLTU  ";
                    FN_MULT:    mnemonic = "MULT  ";
                    FN_MULTU:   mnemonic = "MULTU ";
                    FN_DIV:     mnemonic = "DIV   ";
                    FN_DIVU:    mnemonic = "DIVU  ";
                    // Register jumps and traps
                    FN_JR:      mnemonic = "JR    ";
                    FN_JALR:    mnemonic = "JALR  ";
                    FN_SYSCALL: mnemonic = "SYSC  ";
                    FN_BREAK:   mnemonic = "BREAK ";
                    default:    mnemonic = "N-R   ";
                endcase
            end

            // Immediate logic and arithmetic
            OP_ANDI:  mnemonic = "ANDI  ";
            OP_ORI:   mnemonic = "ORI   ";
            OP_XORI:  mnemonic = "XORI  ";
            OP_LUI:   mnemonic = "LUI   ";
            OP_ADDI:  mnemonic = "ADDI  ";
            OP_ADDIU: mnemonic = "ADDIU ";
            OP_SLTI:  mnemonic = "SLTI  ";
            OP_SLTIU: mnemonic = "SLTIU ";

            // Jumps and branches
            OP_J:     mnemonic = "J     ";
            OP_JAL:   mnemonic = "JAL   ";
            OP_BEQ:   mnemonic = "BEQ   ";
            OP_BNE:   mnemonic = "BNE   ";
            OP_BLEZ:  mnemonic = "BLEZ  ";
            OP_BGTZ:  mnemonic = "BGTZ  ";

            // Loads and stores
            OP_LB:    mnemonic = "LB    ";
            OP_LBU:   mnemonic = "LBU   ";
            OP_LH:    mnemonic = "LH    ";
            OP_LHU:   mnemonic = "LHU   ";
            OP_LW:    mnemonic = "LW    ";
            OP_SB:    mnemonic = "SB    ";
            OP_SH:    mnemonic = "SH    ";
            OP_SW:    mnemonic = "SW    ";

            // Unknown rt here prints as blanks, not N-R
            OP_REGIMM: begin
                case (rt)
                    RI_BLTZ:   mnemonic = "BLTZ  ";
                    RI_BGEZ:   mnemonic = "BGEZ  ";
                    RI_BLTZAL: mnemonic = "BLTZAL";
                    RI_BGEZAL: mnemonic = "BGEZAL";
                    default:   mnemonic = "      ";
                endcase
            end

            //////////////////////////////////////////////////////////////////////
            // COP0, function field first, then the rs move code
            //////////////////////////////////////////////////////////////////////
            OP_COP0: begin
                case (c0_funct)
                    C0_ERET:  mnemonic = "ERET  ";
                    C0_TLBP:  mnemonic = "TLBP  ";
                    C0_TLBR:  mnemonic = "TLBR  ";
                    C0_TLBWI: mnemonic = "TLBWI ";
                    default: begin
                        case (instr[25:21])
                            5'b00100: mnemonic = "MTC0  ";
                            5'b00000: mnemonic = "MFC0  ";
                            default:  mnemonic = "N-R   ";
                        endcase
                    end
                endcase
            end

            default: mnemonic = "N-R   ";
        endcase

        // All-zero word overrides the SLL decode
        if (instr == 32'd0) begin
            mnemonic = "NOP   ";
        end
    end

endmodule

// ==== trace_formatter.sv ====
`include "trace_settings.svh"

module trace_formatter import trace_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        empty,
    input  trace_rec_t  head_rec,
    output logic        pop,
    output trace_char_t trace_char
);

    // Column layout of one line
    localparam int SEQ_POS  = 0;
    localparam int PC_POS   = 3;
    localparam int MNEM_POS = 12;
    localparam int LF_POS   = `TRACE_LINE_CHARS - 1;

    fmt_state_t state;
    logic [4:0] idx;
    trace_rec_t rec;
    mnem_t      mnem;
    trace_rec_t src_rec;
    int         next_pos;
    logic [7:0] next_char;

    function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
        return (nib < 4'd10) ? 8'h30 + 8'(nib) : 8'h37 + 8'(nib);
    endfunction

    // Character at a given column, blanks in the gaps
    function automatic logic [7:0] char_at(input trace_rec_t r, input mnem_t m, input int pos);
        logic [7:0] ch;
        ch = 8'h20;
        if (pos >= SEQ_POS && pos < SEQ_POS + 2) begin
            ch = hex_ascii(r.seq[(SEQ_POS + 1 - pos) * 4 +: 4]);
        end else if (pos >= PC_POS && pos < PC_POS + 8) begin
            ch = hex_ascii(r.pc[(PC_POS + 7 - pos) * 4 +: 4]);
        end else if (pos >= MNEM_POS && pos < MNEM_POS + `TRACE_MNEM_CHARS) begin
            ch = m[(`TRACE_MNEM_CHARS - 1 - (pos - MNEM_POS)) * 8 +: 8];
        end else if (pos == LF_POS) begin
            ch = 8'h0A;
        end
        return ch;
    endfunction

    inst_mnemonic_decoder inst_mnemonic_decoder_inst (
        .instr    (rec.instr),
        .mnemonic (mnem)
    );

    //////////////////////////////////////////////////////////////////////
    // Next character
    //////////////////////////////////////////////////////////////////////

    // Column 0 is built straight from the head record at the pop edge
    assign pop       = (state == FMT_IDLE) && !empty;
    assign src_rec   = (state == FMT_IDLE) ? head_rec : rec;
    assign next_pos  = (state == FMT_IDLE) ? 0 : int'(idx) + 1;
    assign next_char = char_at(src_rec, mnem, next_pos);

    always_ff @(posedge clk) begin
        if (pop) begin
            rec <= head_rec;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Line FSM, idx is the column on the output
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= FMT_IDLE;
            idx        <= '0;
            trace_char <= '0;
        end else begin
            case (state)
                FMT_IDLE: begin
                    trace_char.strobe <= 1'b0;
                    if (!empty) begin
                        state      <= FMT_SEND;
                        idx        <= '0;
                        trace_char <= '{data: next_char, strobe: 1'b1};
                    end
                end
                FMT_SEND: begin
                    if (idx == 5'(LF_POS)) begin
                        state             <= FMT_IDLE;
                        trace_char.strobe <= 1'b0;
                    end else begin
                        idx        <= idx + 5'd1;
                        trace_char <= '{data: next_char, strobe: 1'b1};
                    end
                end
                default: state <= FMT_IDLE;
            endcase
        end
    end

endmodule

// ==== trace_unit_top.sv ====
module trace_unit_top import trace_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        retire_valid,
    input  logic [31:0] retire_pc,
    input  logic [31:0] retire_instr,
    output trace_char_t trace_char,
    output logic [15:0] drop_count
);

    logic       push;
    logic       pop;
    logic       full;
    logic       empty;
    trace_rec_t push_rec;
    trace_rec_t head_rec;

    // Producer side
    trace_capture trace_capture_inst (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_instr (retire_instr),
        .full         (full),
        .push         (push),
        .push_rec     (push_rec),
        .drop_count   (drop_count)
    );

    trace_fifo trace_fifo_inst (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .push_rec (push_rec),
        .pop      (pop),
        .head_rec (head_rec),
        .full     (full),
        .empty    (empty)
    );

    // Consumer side
    trace_formatter trace_formatter_inst (
        .clk        (clk),
        .rst        (rst),
        .empty      (empty),
        .head_rec   (head_rec),
        .pop        (pop),
        .trace_char (trace_char)
    );

endmodule

// ==== trace_unit_sva.sv ====
`include "trace_settings.svh"

module trace_unit_sva import trace_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        push,
    input logic        pop,
    input trace_char_t trace_char
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = `TRACE_FIFO_DEPTH;

    // Buffer occupancy rebuilt from the push and pop strobes alone
    int occupancy;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(push) - int'(pop);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Buffer handshake between capture, FIFO and formatter
    //////////////////////////////////////////////////////////////////////
    property pop_has_data;
        @(posedge clk) disable iff (rst) pop |-> occupancy > 0;
    endproperty

    property push_has_room;
        @(posedge clk) disable iff (rst) push |-> occupancy < DEPTH;
    endproperty

    // One burst of strobes per line and then at least one quiet cycle
    property strobe_spans_line;
        @(posedge clk) disable iff (rst)
            $rose(trace_char.strobe) |->
                trace_char.strobe [*`TRACE_LINE_CHARS] ##1 !trace_char.strobe;
    endproperty

    a_pop_has_data: assert property (pop_has_data)
        else $error("pop issued while the trace FIFO is empty");
    a_push_has_room: assert property (push_has_room)
        else $error("push issued while the trace FIFO is full");
    a_strobe_spans_line: assert property (strobe_spans_line)
        else $error("character strobe length differs from one text line");

endmodule

bind trace_unit_top trace_unit_sva trace_unit_sva_inst (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .pop        (pop),
    .trace_char (trace_char)
);

// ==== tb_trace_unit.sv ====
`include "trace_settings.svh"

module tb_trace_unit import trace_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CASES = 256;
    localparam int MNEM_W    = `TRACE_MNEM_CHARS * 8;

    logic        clk = 1'b0;
    logic        rst;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [31:0] retire_instr;
    trace_char_t trace_char;
    logic [15:0] drop_count;

    // Cases from the data file with the index equal to the expected seq
    int              case_gap   [MAX_CASES];
    logic [31:0]     case_pc    [MAX_CASES];
    logic [31:0]     case_instr [MAX_CASES];
    logic [MNEM_W-1:0] case_mnem [MAX_CASES];
    bit              seen       [MAX_CASES];
    int              n_cases;
    bit              cases_loaded;

    // Collector and scoreboard state
    logic [7:0] line_buf [32];
    int         line_len;
    int         lines_received;
    int         last_seq = -1;
    int         sent;
    bit         early_strobe;
    int         tests;
    int         errors;

    trace_unit_top trace_unit_top_inst (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_instr (retire_instr),
        .trace_char   (trace_char),
        .drop_count   (drop_count)
    );

    always #5 clk = ~clk;

    // Upper-case hex digit value or -1 for anything else
    function automatic int hex_digit_value(input logic [7:0] ch);
        if (ch >= "0" && ch <= "9") begin
            return int'(ch - "0");
        end else if (ch >= "A" && ch <= "F") begin
            return int'(ch - "A") + 10;
        end
        return -1;
    endfunction

    function automatic bit parse_hex(input int first, input int digits,
                                     output logic [31:0] value);
        int d;
        value = '0;
        for (int k = 0; k < digits; k++) begin
            d = hex_digit_value(line_buf[first + k]);
            if (d < 0) begin
                return 1'b0;
            end
            value = {value[27:0], 4'(d)};
        end
        return 1'b1;
    endfunction

    // Underscore in the file stands for a blank and short names are padded
    function automatic logic [MNEM_W-1:0] pack_mnemonic(input string tok);
        logic [MNEM_W-1:0] m;
        logic [7:0]        ch;
        for (int k = 0; k < `TRACE_MNEM_CHARS; k++) begin
            ch = (k < tok.len()) ? tok[k] : 8'h20;
            if (ch == "_") begin
                ch = 8'h20;
            end
            m[(`TRACE_MNEM_CHARS - 1 - k) * 8 +: 8] = ch;
        end
        return m;
    endfunction

    task automatic load_cases();
        int          fd;
        string       text;
        string       tok;
        int          gap;
        logic [31:0] pc;
        logic [31:0] instr;
        n_cases = 0;
        fd = $fopen("trace_cases.txt", "r");
        if (fd != 0) begin
            while ($fgets(text, fd) != 0) begin
                if (text.len() > 1 && text[0] != "#" && n_cases < MAX_CASES) begin
                    if ($sscanf(text, "%d %h %h %s", gap, pc, instr, tok) == 4) begin
                        case_gap[n_cases]   = gap;
                        case_pc[n_cases]    = pc;
                        case_instr[n_cases] = instr;
                        case_mnem[n_cases]  = pack_mnemonic(tok);
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Line checks with one test per received line
    //////////////////////////////////////////////////////////////////////
    task automatic check_line();
        logic [31:0]       seq_v;
        logic [31:0]       pc_v;
        logic [MNEM_W-1:0] mnem_v;
        int                err0;
        err0 = errors;
        lines_received++;
        if (line_len != `TRACE_LINE_CHARS) begin
            $display("Line %0d has %0d characters instead of %0d",
                     lines_received, line_len, `TRACE_LINE_CHARS);
            errors++;
        end else if (line_buf[2] != 8'h20 || line_buf[11] != 8'h20) begin
            $display("Line %0d lacks the blank after the seq or PC field", lines_received);
            errors++;
        end else if (!parse_hex(0, 2, seq_v) || !parse_hex(3, 8, pc_v)) begin
            $display("Line %0d has a seq or PC digit that is not upper-case hex",
                     lines_received);
            errors++;
        end else if (int'(seq_v) <= last_seq || int'(seq_v) >= sent) begin
            $display("CHECK FAILED seq: got 0x%02h after 0x%02h with %0d sent",
                     seq_v, last_seq, sent);
            errors++;
        end else begin
            last_seq    = int'(seq_v);
            seen[seq_v] = 1'b1;
            for (int k = 0; k < `TRACE_MNEM_CHARS; k++) begin
                mnem_v[(`TRACE_MNEM_CHARS - 1 - k) * 8 +: 8] = line_buf[12 + k];
            end
            if (pc_v != case_pc[seq_v]) begin
                $display("CHECK FAILED pc: got 0x%08h expected 0x%08h", pc_v, case_pc[seq_v]);
                errors++;
            end
            if (mnem_v != case_mnem[seq_v]) begin
                $display("CHECK FAILED mnemonic: got 0x%h expected 0x%h",
                         mnem_v, case_mnem[seq_v]);
                errors++;
            end
        end
        tests++;
        $display("Line %0d seq %0d: %s", lines_received, seq_v,
                 (errors == err0) ? "ok" : "wrong");
    endtask

    // Collector assembles characters up to each line feed
    always @(posedge clk) begin
        if (!rst && trace_char.strobe) begin
            if (sent == 0) begin
                early_strobe = 1'b1;
            end
            if (line_len < 32) begin
                line_buf[line_len] = trace_char.data;
            end
            line_len++;
            if (trace_char.data == 8'h0A) begin
                check_line();
                line_len = 0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus and closing checks
    //////////////////////////////////////////////////////////////////////
    task automatic run_tests();
        int idle;
        int burst;
        int longest;
        int burst_end;
        int expected_drops;
        bit dropped;
        int err0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        idle = 20 + int'($urandom % 32);
        repeat (idle) @(posedge clk);
        @(negedge clk);
        err0 = errors;
        if (early_strobe) begin
            $display("A character strobe appeared before the first retirement");
            errors++;
        end
        if (drop_count != 16'h0) begin
            $display("CHECK FAILED drop_count: got 0x%04h expected 0x0000", drop_count);
            errors++;
        end
        tests++;
        $display("Reset state over %0d idle cycles: %s", idle,
                 (errors == err0) ? "ok" : "wrong");

        burst     = 0;
        longest   = 0;
        burst_end = 0;
        for (int i = 0; i < n_cases; i++) begin
            repeat (case_gap[i]) begin
                @(posedge clk);
                retire_valid <= 1'b0;
            end
            @(posedge clk);
            retire_valid <= 1'b1;
            retire_pc    <= case_pc[i];
            retire_instr <= case_instr[i];
            sent         <= sent + 1;
            burst = (case_gap[i] == 0) ? burst + 1 : 1;
            if (burst > longest) begin
                longest   = burst;
                burst_end = i;
            end
        end
        @(posedge clk);
        retire_valid <= 1'b0;

        // Drained once every retirement is a line or a drop
        @(negedge clk);
        while (lines_received + int'(drop_count) != sent) begin
            @(negedge clk);
        end

        // Buffer and formatter latch absorb depth plus one of a short burst
        expected_drops = (longest > `TRACE_FIFO_DEPTH + 1) ?
                         longest - (`TRACE_FIFO_DEPTH + 1) : 0;
        err0 = errors;
        if (int'(drop_count) != expected_drops) begin
            $display("CHECK FAILED drop_count: got 0x%04h expected 0x%04h",
                     drop_count, 16'(expected_drops));
            errors++;
        end
        if (drop_count == 16'h0) begin
            $display("No retirement was dropped in a burst of %0d", longest);
            errors++;
        end

        // The tail of the burst is what overflows
        for (int s = 0; s < sent; s++) begin
            dropped = (s > burst_end - expected_drops) && (s <= burst_end);
            if (seen[s] == dropped) begin
                if (dropped) begin
                    $display("Seq %0d was printed although it should be dropped", s);
                end else begin
                    $display("Seq %0d was never printed", s);
                end
                errors++;
            end
        end
        tests++;
        $display("Overflow burst %0d over depth %0d, %0d sent, %0d dropped: %s",
                 longest, `TRACE_FIFO_DEPTH, sent, drop_count,
                 (errors == err0) ? "ok" : "wrong");

        $display("Tests %0d, lines %0d, errors %0d", tests, lines_received, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin
        rst          = 1'b1;
        retire_valid = 1'b0;
        retire_pc    = '0;
        retire_instr = '0;
        void'($urandom(32'h53dc_2819));
        load_cases();
        cases_loaded = 1'b1;
        if (n_cases == 0) begin
            $display("No retirement could be read from trace_cases.txt");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            run_tests();
        end
    end

    // Watchdog sized from the number of cases
    initial begin
        wait (cases_loaded);
        repeat (n_cases * 25 + 200) @(posedge clk);
        $display("Run did not drain in time, %0d lines and %0d drops for %0d sent",
                 lines_received, drop_count, sent);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== trace_cases.txt ====
# gap in cycles then pc then instruction word then expected mnemonic
# An underscore in the mnemonic stands for a blank and gap 0 means back to back
25 00400000 00221821 ADDU
25 00400004 34021234 ORI
25 00400008 0C100004 JAL
25 0040000C 10220004 BEQ
25 00400010 8FA80004 LW
25 00400014 AFA80008 SW
25 00400018 04910010 BGEZAL
25 0040001C 42000018 ERET
25 00400020 40886000 MTC0
25 00400024 00000000 NOP
25 00400028 FC000000 N-R
25 0040002C 04030000 ______
25 00400100 27BDFFF8 ADDIU
0 00400104 3C011000 LUI
0 00400108 00031100 SLL
0 0040010C 00C72823 SUBU
0 00400110 00852024 AND
0 00400114 012A402A SLT
0 00400118 08100000 J
0 0040011C 1440FFFD BNE
0 00400120 80830000 LB
0 00400124 A0830001 SB
0 00400128 94860002 LHU
0 0040012C 04E00008 BLTZ
0 00400130 40026000 MFC0
0 00400134 42000002 TLBWI

// ==== sources.f ====
+incdir+.
mips_isa_pkg.sv
trace_pkg.sv
trace_capture.sv
trace_fifo.sv
inst_mnemonic_decoder.sv
trace_formatter.sv
trace_unit_top.sv
trace_unit_sva.sv
tb_trace_unit.sv
